/* sim.f */
+incdir+logic
logic/usb_phy_pkg.sv
logic/usb_line_monitor.sv
logic/usb_tx_serializer.sv
logic/usb_rx_deserializer.sv
logic/usb_phy_ctrl.sv
logic/usb_phy.sv
dv/usb_phy_sva.sv
dv/usb_phy_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the USB PHY testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -Wno-fatal --top-module usb_phy_tb -f sim.f -o usb_phy_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

./obj_dir/usb_phy_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$log"; then
	exit 0
fi
echo "Pass message not found in $log."
exit 1

/* dv/usb_phy_tb.sv */
// Testbench for the two-port USB PHY.
// Random packets in both directions, bus reset, disconnect and keep-alive,
// checked against line encoder and decoder models.

`default_nettype none

`include "usb_phy_macros.svh"

module usb_phy_tb;

	import usb_phy_pkg::*;

	localparam line_state_t ls_se0 = 2'd0;
	localparam line_state_t ls_j   = 2'd1;
	localparam line_state_t ls_k   = 2'd2;

	logic        usb_clk;
	logic        usb_rst;
	logic        usba_rcv, usba_vp_in, usba_vm_in;
	logic        usbb_rcv, usbb_vp_in, usbb_vm_in;
	logic        port_sel_rx;
	logic [1:0]  port_sel_tx;
	usb_byte_t   tx_data;
	logic        tx_valid;
	logic [1:0]  generate_reset;
	logic        generate_eop;
	logic        usba_vp_out, usba_vm_out, usba_oe_n;
	logic        usbb_vp_out, usbb_vm_out, usbb_oe_n;
	logic        usba_discon, usbb_discon;
	line_state_t line_state_a, line_state_b;
	logic        tx_ready, tx_busy;
	usb_byte_t   rx_data;
	logic        rx_valid, rx_active;

	line_state_t [1:0] enc_state; // Device side line level per port, {vm, vp}.
	usb_byte_t pkt[$]; // Current packet, sync byte first.
	usb_byte_t got_q[$]; // Bytes recovered from the pads.
	usb_byte_t rx_q[$]; // Bytes delivered by rx_valid.

	usb_phy usb_phy_i (.*);

	// Pads loop the PHY drive back while enabled, else the device model drives.
	assign usba_vp_in = usba_oe_n ? enc_state[0][0] : usba_vp_out;
	assign usba_vm_in = usba_oe_n ? enc_state[0][1] : usba_vm_out;
	assign usba_rcv   = usba_vp_in; // Receiver follows D+.
	assign usbb_vp_in = usbb_oe_n ? enc_state[1][0] : usbb_vp_out;
	assign usbb_vm_in = usbb_oe_n ? enc_state[1][1] : usbb_vm_out;
	assign usbb_rcv   = usbb_vp_in;

	initial begin
		usb_clk = 1'b0;
		forever #4 usb_clk = ~usb_clk;
	end

	always @(posedge usb_clk) begin
		if (rx_valid)
			rx_q.push_back(rx_data);
	end

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic give_up(input string what);
		$display("%s", what);
		stop_run();
	endtask

	function automatic logic [2:0] port_pins(input logic p);
		return p ? {usbb_oe_n, usbb_vp_out, usbb_vm_out} : {usba_oe_n, usba_vp_out, usba_vm_out};
	endfunction

	function automatic logic discon_of(input logic p);
		return p ? usbb_discon : usba_discon;
	endfunction

	function automatic line_state_t line_state_of(input logic p);
		return p ? line_state_b : line_state_a;
	endfunction

	function automatic line_state_t toggled(input line_state_t s);
		return (s == ls_j) ? ls_k : ls_j;
	endfunction

	task automatic make_packet();
		int len;
		pkt = {};
		pkt.push_back(`USB_SYNC_BYTE);
		len = 1 + $urandom % 8;
		repeat (len) begin
			if ($urandom % 4 == 0)
				pkt.push_back(8'hff); // Long runs of ones force stuffing.
			else
				pkt.push_back(8'($urandom));
		end
	endtask

	task automatic wait_oe_low(input logic p);
		int n;
		logic [2:0] pins;
		n = 0;
		pins = port_pins(p);
		while (pins[2]) begin
			@(posedge usb_clk);
			pins = port_pins(p);
			n++;
			if (n > 100)
				give_up("The selected port never started driving.");
		end
	endtask

	task automatic wait_tx_idle();
		int n;
		n = 0;
		while (tx_busy) begin
			@(posedge usb_clk);
			n++;
			if (n > 400)
				give_up("tx_busy never fell after a packet.");
		end
		repeat (4) @(posedge usb_clk);
	endtask

	// Host side: hold each byte until the serializer takes it.
	task automatic feed_bytes();
		int n;
		foreach (pkt[i]) begin
			tx_data  <= pkt[i];
			tx_valid <= 1'b1;
			n = 0;
			do begin
				@(posedge usb_clk);
				n++;
				if (n > 200)
					give_up("tx_ready never took a byte.");
			end while (!tx_ready);
		end
		tx_valid <= 1'b0;
	endtask

	// Samples mid-bit, undoes NRZI and stuffing, expects SE0 SE0 J at the end.
	task automatic decode_packet(input logic p);
		logic [2:0] pins;
		logic [2:0] other;
		logic       level;
		logic       bitv;
		logic       done;
		usb_byte_t  cur;
		int         ones;
		int         nbits;
		int         se0s;
		int         cyc;
		got_q = {};
		level = 1'b1; // Packet starts from J.
		cur   = '0;
		ones  = 0;
		nbits = 0;
		se0s  = 0;
		cyc   = 0;
		done  = 1'b0;
		wait_oe_low(p);
		while (!done) begin
			other = port_pins(~p);
			check("oe_n of unselected port", other[2], 1);
			check("tx_busy", tx_busy, 1);
			if (cyc % `USB_OVERSAMPLE == 2) begin
				pins = port_pins(p);
				check("oe_n of selected port", pins[2], 0);
				if (pins[1:0] == 2'b00)
					se0s++;
				else if (se0s > 0) begin
					check("EOP J level", pins[1:0], 2'b10);
					check("SE0 bits in EOP", se0s, 2);
					done = 1'b1;
				end else begin
					bitv  = (pins[1] == level); // No change is a one.
					level = pins[1];
					if (ones == `USB_STUFF_LIMIT) begin
						check("stuffed bit", bitv, 0);
						ones = 0;
					end else begin
						cur  = {bitv, cur[7:1]}; // LSB arrives first.
						ones = bitv ? ones + 1 : 0;
						nbits++;
						if (nbits % 8 == 0)
							got_q.push_back(cur);
					end
				end
			end
			if (!done) begin
				@(posedge usb_clk);
				cyc++;
				if (cyc > 1000)
					give_up("The transmitted packet never ended.");
			end
		end
		check("leftover decoded bits", nbits % 8, 0);
		repeat (2) @(posedge usb_clk);
		pins = port_pins(p);
		check("oe_n after EOP", pins[2], 1);
	endtask

	task automatic drive_symbol(input logic p, input line_state_t sym);
		enc_state[p] <= sym;
		repeat (`USB_OVERSAMPLE) @(posedge usb_clk);
	endtask

	// Device side encoder. Ones are counted from the start of sync.
	task automatic encode_packet(input logic p);
		line_state_t level;
		logic        b;
		int          ones;
		int          k;
		level = ls_j;
		ones  = 0;
		foreach (pkt[i]) begin
			for (k = 0; k < 8; k++) begin
				b = pkt[i][k];
				if (!b)
					level = toggled(level);
				drive_symbol(p, level);
				ones = b ? ones + 1 : 0;
				if (ones == `USB_STUFF_LIMIT) begin
					level = toggled(level); // Stuffed zero.
					drive_symbol(p, level);
					ones = 0;
				end
			end
		end
		drive_symbol(p, ls_se0);
		drive_symbol(p, ls_se0);
		drive_symbol(p, ls_j);
	endtask

	task automatic expect_reset_drive(input logic [1:0] bits);
		if (bits[0])
			check("port A pads in bus reset", port_pins(1'b0), 3'b000);
		if (bits[1])
			check("port B pads in bus reset", port_pins(1'b1), 3'b000);
	endtask

	task automatic transmit_packets(input int count);
		logic p;
		repeat (count) begin
			p = 1'($urandom % 2);
			port_sel_tx <= p ? 2'b10 : 2'b01;
			port_sel_rx <= ($urandom % 2 == 0) ? p : ~p; // Own port half the time.
			make_packet();
			@(posedge usb_clk);
			rx_q = {};
			fork
				feed_bytes();
				decode_packet(p);
			join
			@(posedge usb_clk);
			check("tx_busy after EOP", tx_busy, 0);
			check("rx_valid count during own transmit", rx_q.size(), 0);
			check("decoded byte count", got_q.size(), pkt.size());
			foreach (got_q[i])
				check("decoded byte", got_q[i], pkt[i]);
			repeat (4) @(posedge usb_clk);
		end
	endtask

	task automatic receive_packets(input int count);
		logic r;
		repeat (count) begin
			r = 1'($urandom % 2);
			port_sel_rx <= r;
			port_sel_tx <= 2'b00;
			make_packet();
			@(posedge usb_clk);
			rx_q = {};
			encode_packet(r);
			repeat (2) @(posedge usb_clk);
			check("rx_active after EOP", rx_active, 0);
			check("received byte count", rx_q.size(), pkt.size() - 1);
			foreach (rx_q[i])
				check("rx_data", rx_q[i], pkt[i + 1]);
			rx_q = {};
			encode_packet(~r); // Same traffic on the other port.
			repeat (8) @(posedge usb_clk);
			check("rx_valid count from unselected port", rx_q.size(), 0);
		end
	endtask

	task automatic bus_reset();
		logic [1:0] bits;
		int         hold;
		repeat (6) begin
			bits = 2'(1 + $urandom % 3);
			hold = 4 + $urandom % 40;
			generate_reset <= bits;
			repeat (hold) begin
				@(posedge usb_clk);
				expect_reset_drive(bits);
			end
			generate_reset <= 2'b00;
			repeat (4) @(posedge usb_clk);
		end
		// Reset while a packet is on the wire.
		repeat (4) begin
			port_sel_tx <= ($urandom % 2 == 0) ? 2'b01 : 2'b10;
			make_packet();
			@(posedge usb_clk);
			fork
				feed_bytes();
				begin
					repeat (4 + $urandom % 20) @(posedge usb_clk);
					bits = 2'(1 + $urandom % 3);
					generate_reset <= bits;
					repeat (12) begin
						@(posedge usb_clk);
						expect_reset_drive(bits);
					end
					generate_reset <= 2'b00;
				end
			join
			wait_tx_idle();
		end
	endtask

	task automatic disconnect();
		logic p;
		int   n;
		p = 1'($urandom % 2);
		port_sel_tx <= 2'b00;
		enc_state[p] <= ls_se0;
		repeat (100) @(posedge usb_clk);
		check("discon after 100 SE0 cycles", discon_of(p), 0);
		check("line_state during SE0", line_state_of(p), ls_se0);
		check("line_state of other port", line_state_of(~p), ls_j);
		enc_state[p] <= ls_j;
		repeat (8) @(posedge usb_clk);
		check("line_state after J returns", line_state_of(p), ls_j);
		enc_state[p] <= ls_se0;
		repeat (150) @(posedge usb_clk);
		check("discon after 150 SE0 cycles", discon_of(p), 1);
		check("discon of other port", discon_of(~p), 0);
		enc_state[p] <= ls_j;
		n = 0;
		do begin
			@(posedge usb_clk);
			n++;
		end while (discon_of(p) && n < 4);
		check("discon after J returns", discon_of(p), 0);
		repeat (8) @(posedge usb_clk);
	endtask

	task automatic keep_alive(input int count);
		logic       p;
		logic [2:0] pins;
		int         c;
		repeat (count) begin
			p = 1'($urandom % 2);
			port_sel_tx <= p ? 2'b10 : 2'b01;
			@(posedge usb_clk);
			generate_eop <= 1'b1;
			@(posedge usb_clk);
			generate_eop <= 1'b0;
			wait_oe_low(p);
			for (c = 0; c < 12; c++) begin
				pins = port_pins(p); // Two SE0 bits, then one J bit.
				check("keep-alive drive", pins, (c < 8) ? 3'b000 : 3'b010);
				check("tx_ready during keep-alive", tx_ready, 0);
				@(posedge usb_clk);
			end
			pins = port_pins(p);
			check("oe_n after keep-alive", pins[2], 1);
			repeat (4) @(posedge usb_clk);
		end
	endtask

	initial begin
		usb_rst        = 1'b1;
		port_sel_rx    = 1'b0;
		port_sel_tx    = 2'b00;
		tx_data        = '0;
		tx_valid       = 1'b0;
		generate_reset = 2'b00;
		generate_eop   = 1'b0;
		enc_state      = {ls_j, ls_j}; // Idle bus.
		void'($urandom(32'h5421_2fd2));
		repeat (8) @(posedge usb_clk);
		usb_rst <= 1'b0;
		@(posedge usb_clk);
		check("usba_oe_n after reset", usba_oe_n, 1);
		check("usbb_oe_n after reset", usbb_oe_n, 1);
		check("tx_ready after reset", tx_ready, 0);
		check("tx_busy after reset", tx_busy, 0);
		check("rx_valid after reset", rx_valid, 0);
		check("rx_active after reset", rx_active, 0);
		check("discon after reset", {usba_discon, usbb_discon}, 0);
		repeat (4) @(posedge usb_clk);
		transmit_packets(12);
		receive_packets(12);
		bus_reset();
		disconnect();
		keep_alive(4);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/usb_phy_sva.sv */
// USB PHY assertions.
// Strobe rules, bus reset drive and post-reset pad state on the top level.

`default_nettype none

module usb_phy_sva (
	input wire       usb_clk,
	input wire       usb_rst,
	input wire       tx_valid,
	input wire       tx_ready,
	input wire       rx_valid,
	input wire       rx_active,
	input wire [1:0] generate_reset,
	input wire       usba_vp_out,
	input wire       usba_vm_out,
	input wire       usba_oe_n,
	input wire       usbb_vp_out,
	input wire       usbb_vm_out,
	input wire       usbb_oe_n
);

	// Acknowledge only answers a pending byte, and lasts one cycle.
	tx_ready_needs_valid: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |-> tx_valid ##1 !tx_ready)
		else $error("tx_ready without tx_valid or longer than one cycle.");

	rx_valid_inside_packet: assert property (@(posedge usb_clk) disable iff (usb_rst)
		rx_valid |-> rx_active) else $error("rx_valid outside rx_active.");

	// Bus reset forces SE0 with the driver on.
	reset_drive_a: assert property (@(posedge usb_clk)
		generate_reset[0] |-> !usba_oe_n && !usba_vp_out && !usba_vm_out)
		else $error("Port A not in SE0 during bus reset.");
	reset_drive_b: assert property (@(posedge usb_clk)
		generate_reset[1] |-> !usbb_oe_n && !usbb_vp_out && !usbb_vm_out)
		else $error("Port B not in SE0 during bus reset.");

	post_reset_idle: assert property (@(posedge usb_clk) $fell(usb_rst) |->
		(usba_oe_n || generate_reset[0]) && (usbb_oe_n || generate_reset[1]))
		else $error("A port drives right after reset.");

endmodule

bind usb_phy usb_phy_sva sva_checker (.usb_clk, .usb_rst, .tx_valid, .tx_ready, .rx_valid,
	.rx_active, .generate_reset, .usba_vp_out, .usba_vm_out, .usba_oe_n, .usbb_vp_out,
	.usbb_vm_out, .usbb_oe_n);

`default_nettype wire

/* logic/usb_phy.sv */
// Two-port full-speed USB PHY.
// One serializer and one deserializer shared between ports A and B.

`default_nettype none

module usb_phy (
	input  wire                         usb_clk,
	input  wire                         usb_rst,
	input  wire                         usba_rcv,
	input  wire                         usba_vp_in,
	input  wire                         usba_vm_in,
	input  wire                         usbb_rcv,
	input  wire                         usbb_vp_in,
	input  wire                         usbb_vm_in,
	input  wire                         port_sel_rx,
	input  wire [1:0]                   port_sel_tx,
	input  wire usb_phy_pkg::usb_byte_t tx_data,
	input  wire                         tx_valid,
	input  wire [1:0]                   generate_reset,
	input  wire                         generate_eop,
	output logic                        usba_vp_out,
	output logic                        usba_vm_out,
	output logic                        usba_oe_n,
	output logic                        usbb_vp_out,
	output logic                        usbb_vm_out,
	output logic                        usbb_oe_n,
	output logic                        usba_discon,
	output logic                        usbb_discon,
	output usb_phy_pkg::line_state_t    line_state_a,
	output usb_phy_pkg::line_state_t    line_state_b,
	output logic                        tx_ready,
	output logic                        tx_busy,
	output usb_phy_pkg::usb_byte_t      rx_data,
	output logic                        rx_valid,
	output logic                        rx_active
);

	import usb_phy_pkg::*;

	usb_line_t  line_a; // Synchronized port samples.
	usb_line_t  line_b;
	usb_line_t  rx_line; // Selected receive port.
	usb_drive_t tx_drive;
	logic       rx_block;

	usb_line_monitor monitor_a (.usb_clk, .usb_rst, .rcv(usba_rcv), .vp(usba_vp_in),
		.vm(usba_vm_in), .line(line_a), .line_state(line_state_a), .discon(usba_discon));

	usb_line_monitor monitor_b (.usb_clk, .usb_rst, .rcv(usbb_rcv), .vp(usbb_vp_in),
		.vm(usbb_vm_in), .line(line_b), .line_state(line_state_b), .discon(usbb_discon));

	usb_tx_serializer tx_serializer (.usb_clk, .usb_rst, .tx_data, .tx_valid,
		.generate_eop, .tx_ready, .tx_drive);

	usb_rx_deserializer rx_deserializer (.usb_clk, .usb_rst, .rx_line, .rx_block,
		.rx_data, .rx_valid, .rx_active);

	usb_phy_ctrl ctrl (.usb_clk, .usb_rst, .port_sel_rx, .port_sel_tx, .generate_reset,
		.tx_valid, .generate_eop, .tx_drive, .line_a, .line_b, .rx_line, .rx_block,
		.tx_busy, .usba_vp_out, .usba_vm_out, .usba_oe_n, .usbb_vp_out, .usbb_vm_out,
		.usbb_oe_n);

endmodule

`default_nettype wire

/* logic/usb_phy_ctrl.sv */
// USB PHY control.
// Routes the serializer drive to the selected ports, forces SE0 for bus reset,
// picks the receive port, blanks reception during own transmit, tracks busy.

`default_nettype none

module usb_phy_ctrl (
	input  wire                     usb_clk,
	input  wire                     usb_rst,
	input  wire                     port_sel_rx,
	input  wire [1:0]               port_sel_tx,
	input  wire [1:0]               generate_reset,
	input  wire                     tx_valid,
	input  wire                     generate_eop,
	input  wire usb_phy_pkg::usb_drive_t tx_drive,
	input  wire usb_phy_pkg::usb_line_t  line_a,
	input  wire usb_phy_pkg::usb_line_t  line_b,
	output usb_phy_pkg::usb_line_t  rx_line,
	output logic                    rx_block,
	output logic                    tx_busy,
	output logic                    usba_vp_out,
	output logic                    usba_vm_out,
	output logic                    usba_oe_n,
	output logic                    usbb_vp_out,
	output logic                    usbb_vm_out,
	output logic                    usbb_oe_n
);

	logic [1:0] port_en; // Bit 0 is port A, bit 1 is port B.
	logic       oe_d1; // First stage of the blanking delay.

	assign rx_line = port_sel_rx ? line_b : line_a; // Receive port select.

	// A port drives when selected for transmit or held in bus reset.
	assign port_en = ({2{tx_drive.oe}} & port_sel_tx) | generate_reset;

	// Bus reset overrides the data with SE0.
	assign usba_oe_n   = ~port_en[0];
	assign usba_vp_out = tx_drive.dp & ~generate_reset[0];
	assign usba_vm_out = tx_drive.dm & ~generate_reset[0];
	assign usbb_oe_n   = ~port_en[1];
	assign usbb_vp_out = tx_drive.dp & ~generate_reset[1];
	assign usbb_vm_out = tx_drive.dm & ~generate_reset[1];

	// Our own packet loops back through the pads and the two-stage
	// synchronizer, so the blanking follows oe by the same two cycles.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			oe_d1    <= 1'b0;
			rx_block <= 1'b0;
			tx_busy  <= 1'b0;
		end else begin
			oe_d1    <= tx_drive.oe;
			rx_block <= oe_d1;
			if (generate_eop | tx_valid)
				tx_busy <= 1'b1; // Request seen.
			else if (oe_d1 & ~tx_drive.oe)
				tx_busy <= 1'b0; // Cycle after oe fell.
		end
	end

endmodule

`default_nettype wire

/* logic/usb_rx_deserializer.sv */
// USB receive deserializer.
// Recovers bit timing from 4x oversampling, finds sync, undoes NRZI and
// bit stuffing, and assembles bytes while rx_active is high.

`default_nettype none

`include "usb_phy_macros.svh"

module usb_rx_deserializer (
	input  wire                        usb_clk,
	input  wire                        usb_rst,
	input  wire usb_phy_pkg::usb_line_t rx_line,
	input  wire                        rx_block,
	output usb_phy_pkg::usb_byte_t     rx_data,
	output logic                       rx_valid,
	output logic                       rx_active
);

	import usb_phy_pkg::*;

	localparam bit_phase_t mid_phase  = bit_phase_t'(`USB_OVERSAMPLE / 2);
	localparam bit_phase_t last_phase = bit_phase_t'(`USB_OVERSAMPLE - 1);

	rx_state_e  state;
	bit_phase_t phase; // Cycles since the last edge, modulo one bit.
	logic       rcv_d; // Previous rcv, for edge detection.
	logic       last_rcv; // Level of the previous sampled bit.
	usb_byte_t  shreg; // Newest bit enters at the top.
	usb_byte_t  shreg_next;
	logic [2:0] bit_cnt;
	logic [2:0] ones; // Run of decoded ones.
	logic       se0;
	logic       sample;
	logic       rx_bit;
	logic       stuffed;
	logic       byte_done;

	assign se0        = ~rx_line.vp & ~rx_line.vm;
	assign sample     = (phase == mid_phase); // Middle of the bit.
	assign rx_bit     = (rx_line.rcv == last_rcv); // No change decodes as one.
	assign shreg_next = {rx_bit, shreg[7:1]};
	assign stuffed    = (ones == 3'(`USB_STUFF_LIMIT)); // This bit gets dropped.
	assign byte_done  = sample & ~rx_block & (state == rx_st_data) & ~se0 & ~stuffed
		& (bit_cnt == 3'd7);
	assign rx_active  = (state == rx_st_data);

	always_ff @(posedge usb_clk) begin
		rcv_d <= rx_line.rcv;
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state    <= rx_st_idle;
			phase    <= '0;
			last_rcv <= 1'b1;
			bit_cnt  <= '0;
			ones     <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= byte_done;
			// Every edge re-aligns the phase.
			if (rx_line.rcv != rcv_d)
				phase <= bit_phase_t'(1);
			else if (phase == last_phase)
				phase <= '0;
			else
				phase <= phase + 1'b1;

			if (rx_block) begin
				state    <= rx_st_idle; // Our own packet is on the line.
				last_rcv <= 1'b1;
			end else begin
				case (state)
					rx_st_idle: begin
						if (sample) begin
							last_rcv <= rx_line.rcv;
							if (!se0 && !rx_line.rcv)
								state <= rx_st_sync; // First K after idle.
						end
					end
					rx_st_sync: begin
						if (sample) begin
							last_rcv <= rx_line.rcv;
							if (se0)
								state <= rx_st_idle;
							else if (rx_bit) begin
								// The only one in sync is its final K K.
								if (shreg_next == `USB_SYNC_BYTE) begin
									state   <= rx_st_data;
									bit_cnt <= '0;
									ones    <= 3'd1;
								end else
									state <= rx_st_idle;
							end
						end
					end
					rx_st_data: begin
						if (sample) begin
							last_rcv <= rx_line.rcv;
							if (se0)
								state <= rx_st_eop;
							else if (stuffed)
								ones <= '0;
							else begin
								ones    <= rx_bit ? ones + 3'd1 : '0;
								bit_cnt <= bit_cnt + 3'd1;
							end
						end
					end
					default: begin
						if (!se0)
							state <= rx_st_idle; // Back to J.
					end
				endcase
			end
		end
	end

	// Payload. The K that leaves idle counts as the first zero of sync.
	always_ff @(posedge usb_clk) begin
		if (sample) begin
			if (state == rx_st_idle)
				shreg <= 8'h7f;
			else if (state == rx_st_sync || (state == rx_st_data && !stuffed))
				shreg <= shreg_next;
		end
		if (byte_done)
			rx_data <= shreg_next;
	end

endmodule

`default_nettype wire

/* logic/usb_tx_serializer.sv */
// USB transmit serializer.
// Shifts bytes out LSB first with bit stuffing and NRZI, closes each packet
// with EOP, and sends a lone EOP on request for keep-alive.

`default_nettype none

`include "usb_phy_macros.svh"

module usb_tx_serializer (
	input  wire                        usb_clk,
	input  wire                        usb_rst,
	input  wire usb_phy_pkg::usb_byte_t tx_data,
	input  wire                        tx_valid,
	input  wire                        generate_eop,
	output logic                       tx_ready,
	output usb_phy_pkg::usb_drive_t    tx_drive
);

	import usb_phy_pkg::*;

	localparam bit_phase_t last_phase = bit_phase_t'(`USB_OVERSAMPLE - 1);

	tx_state_e  state;
	bit_phase_t phase; // Cycle within the current bit.
	usb_byte_t  shreg; // Bit 0 is the bit on the line.
	logic [2:0] bit_idx; // Data bit index, or EOP SE0 bit count.
	logic [2:0] ones; // Run of ones sent so far.
	logic       level; // NRZI line level, 1 is J.
	logic       bit_end;
	logic       stuff;
	logic       byte_end;
	logic       next_bit;

	assign bit_end  = (phase == last_phase);
	assign stuff    = (ones == 3'(`USB_STUFF_LIMIT)); // Next bit is a stuffed zero.
	assign byte_end = bit_end & ~stuff & (bit_idx == 3'd7);
	assign next_bit = byte_end ? tx_data[0] : shreg[1];

	// Load strobe, also the acknowledge to the host.
	assign tx_ready = tx_valid & ((state == tx_st_idle) | ((state == tx_st_data) & byte_end));

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state   <= tx_st_idle;
			phase   <= '0;
			bit_idx <= '0;
			ones    <= '0;
			level   <= 1'b1;
		end else begin
			phase <= (state == tx_st_idle || bit_end) ? '0 : phase + 1'b1;
			case (state)
				tx_st_idle: begin
					if (tx_ready) begin
						// Packet starts from J, so a one stays J and a zero goes K.
						state   <= tx_st_data;
						level   <= tx_data[0];
						ones    <= {2'b00, tx_data[0]};
						bit_idx <= '0;
					end else if (generate_eop) begin
						state   <= tx_st_eop_se0; // Keep-alive.
						bit_idx <= '0;
					end
				end
				tx_st_data: begin
					if (bit_end) begin
						if (stuff) begin
							level <= ~level;
							ones  <= '0;
						end else if (byte_end && !tx_valid) begin
							state   <= tx_st_eop_se0; // Host ran dry.
							bit_idx <= '0;
						end else begin
							level   <= next_bit ? level : ~level; // Zero toggles.
							ones    <= next_bit ? ones + 3'd1 : '0;
							bit_idx <= bit_idx + 3'd1; // Wraps to 0 on a new byte.
						end
					end
				end
				tx_st_eop_se0: begin
					if (bit_end) begin
						if (bit_idx[0])
							state <= tx_st_eop_j; // Two SE0 bits done.
						bit_idx <= bit_idx + 3'd1;
					end
				end
				default: begin
					if (bit_end)
						state <= tx_st_idle;
				end
			endcase
		end
	end

	// Payload shifter.
	always_ff @(posedge usb_clk) begin
		if (tx_ready)
			shreg <= tx_data;
		else if (state == tx_st_data && bit_end && !stuff)
			shreg <= shreg >> 1;
	end

	always_comb begin
		tx_drive.oe = (state != tx_st_idle);
		tx_drive.dp = 1'b1; // J unless told otherwise.
		tx_drive.dm = 1'b0;
		case (state)
			tx_st_data: begin
				tx_drive.dp = level;
				tx_drive.dm = ~level;
			end
			tx_st_eop_se0: begin
				tx_drive.dp = 1'b0;
				tx_drive.dm = 1'b0;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/usb_line_monitor.sv */
// USB line monitor.
// Synchronizes one port's receiver inputs and flags disconnect on long SE0.

`default_nettype none

`include "usb_phy_macros.svh"

module usb_line_monitor (
	input  wire                       usb_clk,
	input  wire                       usb_rst,
	input  wire                       rcv,
	input  wire                       vp,
	input  wire                       vm,
	output usb_phy_pkg::usb_line_t    line,
	output usb_phy_pkg::line_state_t  line_state,
	output logic                      discon
);

	import usb_phy_pkg::*;

	usb_line_t   line_meta; // First synchronizer stage.
	discon_cnt_t se0_cnt; // Consecutive SE0 cycles.

	// Two flops on the asynchronous pad inputs.
	always_ff @(posedge usb_clk) begin
		line_meta <= '{rcv: rcv, vp: vp, vm: vm};
		line      <= line_meta;
	end

	assign line_state = {line.vm, line.vp};

	assign discon = (se0_cnt == discon_cnt_t'(`USB_DISCON_CYCLES)); // Counter saturated.

	// Any non-SE0 state restarts the count.
	always_ff @(posedge usb_clk) begin
		if (usb_rst)
			se0_cnt <= '0;
		else if (line_state != 2'b00)
			se0_cnt <= '0;
		else if (!discon)
			se0_cnt <= se0_cnt + 1'b1;
	end

endmodule

`default_nettype wire

/* logic/usb_phy_pkg.sv */
// USB PHY types.
// Line samples, line drive, state machine encodings and counter widths.

`default_nettype none

`include "usb_phy_macros.svh"

package usb_phy_pkg;

	typedef logic [7:0] usb_byte_t; // One data byte.
	typedef logic [1:0] line_state_t; // Ordered {vm, vp}. SE0 is 0, J is 1, K is 2.

	// Position inside one bit time.
	typedef logic [$clog2(`USB_OVERSAMPLE)-1:0] bit_phase_t;
	typedef logic [$clog2(`USB_DISCON_CYCLES+1)-1:0] discon_cnt_t; // SE0 run length.

	// One port's synchronized receiver sample.
	typedef struct packed {
		logic rcv; // Differential receiver.
		logic vp;
		logic vm;
	} usb_line_t;

	// Serializer drive, shared by both ports.
	typedef struct packed {
		logic dp;
		logic dm;
		logic oe; // Active high here, inverted at the pads.
	} usb_drive_t;

	typedef enum logic [1:0] {tx_st_idle, tx_st_data, tx_st_eop_se0, tx_st_eop_j} tx_state_e;
	typedef enum logic [1:0] {rx_st_idle, rx_st_sync, rx_st_data, rx_st_eop} rx_state_e;

endpackage

`default_nettype wire

/* logic/usb_phy_macros.svh */
// USB PHY constants.
// Full-speed bit timing, stuffing, disconnect detection and sync byte.

`ifndef USB_PHY_MACROS_SVH
`define USB_PHY_MACROS_SVH

// Clock cycles per full-speed bit at 48 MHz.
`define USB_OVERSAMPLE 4

// Consecutive ones after which a zero is stuffed.
`define USB_STUFF_LIMIT 6

// SE0 length in synchronized cycles that flags disconnect, about 2.6 us.
`define USB_DISCON_CYCLES 127

// Sync byte, sent least significant bit first.
`define USB_SYNC_BYTE 8'h80

`endif
